// File: hw/icache_defines.svh
// Icache data array widths
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// ------------------------------------------------------------
// Request side
// ------------------------------------------------------------

// Fetch and refill index, only bits 11:0 reach the banks
`define ICACHE_IDX_W 14

// Refill beat and debug record, four bank words
`define ICACHE_LINE_W 128

// ------------------------------------------------------------
// Bank side
// ------------------------------------------------------------

// Row address: index 11:2 plus the steered way bit
`define ICACHE_ROW_W 11

// Words per bank
`define ICACHE_DEPTH 2048

// One instruction word per bank
`define ICACHE_WORD_W 32

// Interleaved banks, two pairs of two
`define ICACHE_NUM_BANKS 4

`endif

// File: hw/icache_access_pkg.sv
// Icache request types
package icache_access_pkg;

  // ------------------------------------------------------------
  // Access opcode
  // ------------------------------------------------------------

  // Decoded once per cycle from the request strobes
  // At most one strobe is set, so the decode is a plain priority
  typedef enum logic [1:0] {
    // No strobe this cycle
    ACC_IDLE  = 2'd0,
    // Way-specific fetch, one bank read
    ACC_FETCH = 2'd1,
    // Refill beat, all four banks written
    ACC_FILL  = 2'd2,
    // Debug read, all four banks read
    ACC_DEBUG = 2'd3
  } access_op_e;

  // Align keeps this for one cycle
  // and turns FETCH or DEBUG into a valid pulse

endpackage

// File: hw/icache_bank_pkg.sv
// Icache bank types
package icache_bank_pkg;

  // ------------------------------------------------------------
  // Bank pair
  // ------------------------------------------------------------

  // Banks pair up for the refill way bit and the data lanes
  typedef enum logic {
    // Banks 0 and 1, steered by data_wen[0]
    HALF_LOW  = 1'b0,
    // Banks 2 and 3, steered by data_wen[1]
    HALF_HIGH = 1'b1
  } bank_half_e;

  // ------------------------------------------------------------
  // Per-bank port mode
  // ------------------------------------------------------------

  // Stands in for the chip enable and write enable pair of a macro
  typedef enum logic [1:0] {
    BANK_OFF   = 2'd0,
    BANK_READ  = 2'd1,
    BANK_WRITE = 2'd2
  } bank_mode_e;

endpackage

// File: hw/icache_data_steer.sv
// Icache bank request steering
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_data_steer (
  input  logic [`ICACHE_IDX_W-1:0]  data_idx,
  input  logic [`ICACHE_LINE_W-1:0] data_din,
  input  logic [1:0]                data_ren,
  input  logic [1:0]                data_wen,
  input  logic                      dbg_rd,
  input  logic                      dbg_way,
  output icache_bank_pkg::bank_mode_e bank_mode [`ICACHE_NUM_BANKS],
  output logic [`ICACHE_ROW_W-1:0]  bank_row [`ICACHE_NUM_BANKS],
  output logic [`ICACHE_WORD_W-1:0] bank_wdata [`ICACHE_NUM_BANKS],
  output icache_access_pkg::access_op_e req_op,
  output logic [1:0]                fetch_bank
);

  // ------------------------------------------------------------
  // Request classification
  // ------------------------------------------------------------

  // Strobes are exclusive, order only matters for illegal input
  always_comb begin
    if (|data_wen) begin
      req_op = icache_access_pkg::ACC_FILL;
    end else if (dbg_rd) begin
      req_op = icache_access_pkg::ACC_DEBUG;
    end else if (|data_ren) begin
      req_op = icache_access_pkg::ACC_FETCH;
    end else begin
      req_op = icache_access_pkg::ACC_IDLE;
    end
  end

  // Way 1 reads bank idx[1:0]
  // Way 0 reads the same lane in the other pair
  assign fetch_bank = data_ren[1] ? data_idx[1:0] : (data_idx[1:0] ^ 2'b10);

  // ------------------------------------------------------------
  // Per-bank decode
  // ------------------------------------------------------------

  for (genvar b = 0; b < `ICACHE_NUM_BANKS; b++) begin : g_bank
    // Pair this bank belongs to
    localparam icache_bank_pkg::bank_half_e HALF =
      (b >= 2) ? icache_bank_pkg::HALF_HIGH : icache_bank_pkg::HALF_LOW;
    // Odd banks carry the upper word of a 64-bit lane
    localparam int LANE = (b % 2) * `ICACHE_WORD_W;

    logic half_wen;
    logic dbg_way_bit;
    logic way_bit;
    logic rd_en;

    // Refill half strobe for this pair
    assign half_wen = (HALF == icache_bank_pkg::HALF_HIGH) ? data_wen[1] : data_wen[0];

    // High pair follows dbg_way, low pair the inverse
    assign dbg_way_bit = (HALF == icache_bank_pkg::HALF_HIGH) ? dbg_way : !dbg_way;

    // Refilled pair forced to way 1, otherwise idx[1] or debug way
    assign way_bit = half_wen | (dbg_rd ? dbg_way_bit : data_idx[1]);

    assign bank_row[b] = {data_idx[`ICACHE_ROW_W:2], way_bit};

    // Upper 64 bits of the beat go to the pair named by data_wen
    assign bank_wdata[b] = half_wen
                         ? data_din[`ICACHE_LINE_W/2 + LANE +: `ICACHE_WORD_W]
                         : data_din[LANE +: `ICACHE_WORD_W];

    // Debug reads every bank, fetch only the selected one
    assign rd_en = (req_op == icache_access_pkg::ACC_DEBUG)
                || ((req_op == icache_access_pkg::ACC_FETCH) && (fetch_bank == 2'(b)));

    // Former gate enable, now a port mode on the shared clock
    assign bank_mode[b] = (req_op == icache_access_pkg::ACC_FILL) ? icache_bank_pkg::BANK_WRITE
                        : rd_en ? icache_bank_pkg::BANK_READ
                        : icache_bank_pkg::BANK_OFF;
  end

endmodule

// File: hw/icache_data_bank.sv
// Icache data bank RAM
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_data_bank (
  input  logic                        forever_cpuclk,
  input  icache_bank_pkg::bank_mode_e bank_mode,
  input  logic [`ICACHE_ROW_W-1:0]    bank_row,
  input  logic [`ICACHE_WORD_W-1:0]   bank_wdata,
  output logic [`ICACHE_WORD_W-1:0]   bank_rdata
);

  // ------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------

  // Single port, full-word writes only
  logic [`ICACHE_WORD_W-1:0] mem [`ICACHE_DEPTH];

  // Write and read share the one port
  // Read data lands one edge after the enabled read
  always_ff @(posedge forever_cpuclk) begin
    case (bank_mode)
      icache_bank_pkg::BANK_WRITE: begin
        mem[bank_row] <= bank_wdata;
      end
      icache_bank_pkg::BANK_READ: begin
        bank_rdata <= mem[bank_row];
      end
      default: begin
        // Port idle, output keeps the last read word
      end
    endcase
  end

  // Output also holds across writes,
  // same as a macro with its Q latched

endmodule

// File: hw/icache_data_align.sv
// Icache response alignment
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_data_align (
  input  logic                          forever_cpuclk,
  input  logic                          arst_n,
  input  icache_access_pkg::access_op_e req_op,
  input  logic [1:0]                    fetch_bank,
  input  logic [`ICACHE_WORD_W-1:0]     bank_rdata [`ICACHE_NUM_BANKS],
  output logic                          fetch_valid,
  output logic [`ICACHE_WORD_W-1:0]     fetch_data,
  output logic                          dbg_valid,
  output logic [`ICACHE_LINE_W-1:0]     dbg_data
);

  // ------------------------------------------------------------
  // Request context
  // ------------------------------------------------------------

  // Opcode of the read now sitting in the bank outputs
  icache_access_pkg::access_op_e op_q;
  // Bank that served the fetch
  logic [1:0]                    bank_q;

  // Captured on the same edge the banks read
  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      op_q   <= icache_access_pkg::ACC_IDLE;
      bank_q <= 2'b00;
    end else begin
      op_q   <= req_op;
      bank_q <= fetch_bank;
    end
  end

  // ------------------------------------------------------------
  // Response forming
  // ------------------------------------------------------------

  // One-cycle pulses, a new request replaces op_q next edge
  assign fetch_valid = (op_q == icache_access_pkg::ACC_FETCH);
  assign dbg_valid   = (op_q == icache_access_pkg::ACC_DEBUG);

  // Addressed bank word for the fetch
  assign fetch_data = bank_rdata[bank_q];

  // Debug record, bank 3 in the top word down to bank 0
  for (genvar b = 0; b < `ICACHE_NUM_BANKS; b++) begin : g_dbg
    assign dbg_data[b*`ICACHE_WORD_W +: `ICACHE_WORD_W] = bank_rdata[b];
  end

  // Data buses are not qualified
  // and only carry meaning while the matching valid is high

endmodule

// File: hw/icache_data_array.sv
// Icache data array top
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_data_array (
  input  logic                      forever_cpuclk,
  input  logic                      arst_n,
  input  logic [`ICACHE_IDX_W-1:0]  data_idx,
  input  logic [`ICACHE_LINE_W-1:0] data_din,
  input  logic [1:0]                data_ren,
  input  logic [1:0]                data_wen,
  input  logic                      dbg_rd,
  input  logic                      dbg_way,
  output logic                      fetch_valid,
  output logic [`ICACHE_WORD_W-1:0] fetch_data,
  output logic                      dbg_valid,
  output logic [`ICACHE_LINE_W-1:0] dbg_data
);

  // ------------------------------------------------------------
  // Steer to bank wiring
  // ------------------------------------------------------------

  icache_bank_pkg::bank_mode_e   bank_mode [`ICACHE_NUM_BANKS];
  logic [`ICACHE_ROW_W-1:0]      bank_row [`ICACHE_NUM_BANKS];
  logic [`ICACHE_WORD_W-1:0]     bank_wdata [`ICACHE_NUM_BANKS];
  logic [`ICACHE_WORD_W-1:0]     bank_rdata [`ICACHE_NUM_BANKS];
  // Context handed to align
  icache_access_pkg::access_op_e req_op;
  logic [1:0]                    fetch_bank;

  // Request decode
  icache_data_steer i_steer (
    .data_idx   (data_idx),
    .data_din   (data_din),
    .data_ren   (data_ren),
    .data_wen   (data_wen),
    .dbg_rd     (dbg_rd),
    .dbg_way    (dbg_way),
    .bank_mode  (bank_mode),
    .bank_row   (bank_row),
    .bank_wdata (bank_wdata),
    .req_op     (req_op),
    .fetch_bank (fetch_bank)
  );

  // Four banks on the ungated clock
  for (genvar b = 0; b < `ICACHE_NUM_BANKS; b++) begin : g_bank
    icache_data_bank i_bank (
      .forever_cpuclk (forever_cpuclk),
      .bank_mode      (bank_mode[b]),
      .bank_row       (bank_row[b]),
      .bank_wdata     (bank_wdata[b]),
      .bank_rdata     (bank_rdata[b])
    );
  end

  // Response stage
  icache_data_align i_align (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .req_op         (req_op),
    .fetch_bank     (fetch_bank),
    .bank_rdata     (bank_rdata),
    .fetch_valid    (fetch_valid),
    .fetch_data     (fetch_data),
    .dbg_valid      (dbg_valid),
    .dbg_data       (dbg_data)
  );

endmodule

// File: tb/icache_data_array_checker.sv
// Icache data array protocol checks
`timescale 1ns/1ps

module icache_data_array_checker (
  input logic       forever_cpuclk,
  input logic       arst_n,
  input logic [1:0] data_ren,
  input logic [1:0] data_wen,
  input logic       dbg_rd,
  input logic       fetch_valid,
  input logic       dbg_valid
);

  // ------------------------------------------------------------
  // Request legality
  // ------------------------------------------------------------

  // Fetch way and refill half are named by one bit at most
  a_strobe_onehot: assert property (@(posedge forever_cpuclk) disable iff (!arst_n)
    $onehot0(data_ren) && $onehot0(data_wen))
    else $error("data_ren or data_wen has more than one bit set");

  // Only one request kind per cycle
  a_one_kind: assert property (@(posedge forever_cpuclk) disable iff (!arst_n)
    $onehot0({|data_ren, |data_wen, dbg_rd}))
    else $error("fetch, refill and debug strobes overlap");

  // ------------------------------------------------------------
  // Response timing
  // ------------------------------------------------------------

  // Valid pulses exactly one cycle after the strobe, never otherwise
  a_fetch_latency: assert property (@(posedge forever_cpuclk) disable iff (!arst_n)
    fetch_valid == $past(|data_ren))
    else $error("fetch_valid does not follow data_ren by one cycle");

  a_dbg_latency: assert property (@(posedge forever_cpuclk) disable iff (!arst_n)
    dbg_valid == $past(dbg_rd))
    else $error("dbg_valid does not follow dbg_rd by one cycle");

endmodule

// File: tb/icache_data_array_tb.sv
// Icache data array testbench
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_data_array_tb;

  logic                      forever_cpuclk;
  logic                      arst_n;
  logic [`ICACHE_IDX_W-1:0]  data_idx;
  logic [`ICACHE_LINE_W-1:0] data_din;
  logic [1:0]                data_ren;
  logic [1:0]                data_wen;
  logic                      dbg_rd;
  logic                      dbg_way;
  logic                      fetch_valid;
  logic [`ICACHE_WORD_W-1:0] fetch_data;
  logic                      dbg_valid;
  logic [`ICACHE_LINE_W-1:0] dbg_data;

  integer seed;
  int     cycle = 0;
  int     errors = 0;
  int     mark = 0;
  int     tests = 0;
  int     failed = 0;

  // Reference banks
  logic [`ICACHE_WORD_W-1:0] model_mem [`ICACHE_NUM_BANKS][`ICACHE_DEPTH];
  // Expected responses in order with bit 128 marking a debug record
  logic [`ICACHE_LINE_W:0]   exp_q [$];
  int                        exp_cyc [$];

  icache_data_array i_dut (.*);

  bind icache_data_array icache_data_array_checker i_checker (.*);

  always #5 forever_cpuclk = ~forever_cpuclk;
  always @(posedge forever_cpuclk) cycle <= cycle + 1;

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------

  function automatic icache_bank_pkg::bank_half_e half_of(input int b);
    return (b >= 2) ? icache_bank_pkg::HALF_HIGH : icache_bank_pkg::HALF_LOW;
  endfunction

  // Selection table from {way, idx[1:0]} to bank
  function automatic int fetch_bank_of(input logic [2:0] sel);
    case (sel)
      3'b111, 3'b001: return 3;
      3'b110, 3'b000: return 2;
      3'b101, 3'b011: return 1;
      default: return 0;
    endcase
  endfunction

  function automatic logic [11:0] rand_idx();
    logic [31:0] r;
    r = $random(seed);
    return r[11:0];
  endfunction

  // Kind 0 is refill, 1 fetch, 2 debug and 3 idle
  // sel names the refill half or the way
  task automatic issue(input int kind, input logic sel, input logic [11:0] idx);
    logic [`ICACHE_LINE_W-1:0] din;
    logic [`ICACHE_LINE_W-1:0] rec;
    logic                      hot;
    din = {$random(seed), $random(seed), $random(seed), $random(seed)};
    rec = '0;
    @(posedge forever_cpuclk);
    data_idx <= {2'b00, idx};
    data_din <= din;
    data_wen <= (kind == 0) ? {sel, ~sel} : 2'b00;
    data_ren <= (kind == 1) ? {sel, ~sel} : 2'b00;
    dbg_rd   <= (kind == 2);
    dbg_way  <= sel;
    for (int b = 0; b < `ICACHE_NUM_BANKS; b++) begin
      if (kind == 0) begin
        // Named half goes to way 1 with the upper 64 bits
        hot = (half_of(b) == icache_bank_pkg::HALF_HIGH) ? sel : ~sel;
        model_mem[b][{idx[11:2], hot | idx[1]}] = din[(hot ? 64 : 0) + (b % 2) * 32 +: 32];
      end else if (kind == 2) begin
        // Low pair reads the other way
        hot = (half_of(b) == icache_bank_pkg::HALF_HIGH) ? sel : ~sel;
        rec[b*32 +: 32] = model_mem[b][{idx[11:2], hot}];
      end
    end
    if (kind == 1) begin
      rec[31:0] = model_mem[fetch_bank_of({sel, idx[1:0]})][{idx[11:2], idx[1]}];
    end
    if (kind == 1 || kind == 2) begin
      exp_q.push_back({kind == 2, rec});
      exp_cyc.push_back(cycle);
    end
  endtask

  // Narrow keeps rows in a small window for read after write
  task automatic issue_random(input logic narrow);
    logic [31:0] r;
    logic [11:0] idx;
    r = $random(seed);
    idx = rand_idx();
    if (narrow) idx[11:5] = '0;
    issue(int'(r[7:0]) % 3, r[8], idx);
  endtask

  task automatic wait_responses();
    int waited = 0;
    issue(3, 1'b0, 12'd0);
    while (exp_q.size() != 0 && waited < 10) begin
      @(posedge forever_cpuclk);
      waited++;
    end
    assert (exp_q.size() == 0) else begin
      $display("timeout at %0t: %0d responses never arrived", $time, exp_q.size());
      errors++;
      // Drop the lost responses so later tests start clean
      exp_q.delete();
      exp_cyc.delete();
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors != mark) failed++;
    $display("test %0d %s: %s, %0d errors", tests, name,
             (errors == mark) ? "ok" : "FAILED", errors - mark);
    mark = errors;
  endtask

  // ------------------------------------------------------------
  // Response monitor
  // ------------------------------------------------------------

  // Outputs settle after the rising edge, so look at the falling one
  always @(negedge forever_cpuclk) begin : monitor
    logic [`ICACHE_LINE_W:0] want;
    int                      at;
    if (fetch_valid || dbg_valid) begin
      assert (exp_q.size() != 0 && !(fetch_valid && dbg_valid)) else begin
        $display("error at %0t: valid pulse with nothing outstanding or both valids high",
                 $time);
        errors++;
      end
      if (exp_q.size() != 0) begin
        want = exp_q.pop_front();
        at = exp_cyc.pop_front();
        assert (cycle == at + 2) else begin
          $display("mismatch at %0t: response in cycle %0d for request driven in cycle %0d",
                   $time, cycle, at);
          errors++;
        end
        assert (want[128] ? (dbg_valid && dbg_data == want[127:0])
                          : (fetch_valid && fetch_data == want[31:0])) else begin
          $display("mismatch at %0t: expected %s %h, got fetch %0b/%h debug %0b/%h", $time,
                   want[128] ? "debug" : "fetch", want[127:0], fetch_valid, fetch_data,
                   dbg_valid, dbg_data);
          errors++;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------

  initial begin
    logic [11:0] idx_a;
    logic [11:0] idx_b;
    seed = 52307;
    forever_cpuclk = 1'b0;
    arst_n = 1'b0;
    data_idx = '0;
    data_din = '0;
    data_ren = 2'b00;
    data_wen = 2'b00;
    dbg_rd = 1'b0;
    dbg_way = 1'b0;
    repeat (8) @(posedge forever_cpuclk);
    arst_n <= 1'b1;

    repeat (20) begin
      @(negedge forever_cpuclk);
      assert (!fetch_valid && !dbg_valid) else begin
        $display("error at %0t: valid pulse with no request after reset", $time);
        errors++;
      end
    end
    end_test("idle after reset");

    // Every row written once since idx[1] low reaches both ways in each pair
    for (int g = 0; g < `ICACHE_DEPTH / 2; g++) begin
      issue(0, 1'b1, {g[9:0], 2'b00});
      issue(0, 1'b0, {g[9:0], 2'b00});
    end

    repeat (8) begin
      idx_a = rand_idx();
      idx_b = rand_idx();
      issue(0, 1'b1, idx_a);
      issue(0, 1'b0, idx_b);
      issue(2, 1'b0, idx_a);
      issue(2, 1'b1, idx_a);
      issue(2, 1'b0, idx_b);
      issue(2, 1'b1, idx_b);
    end
    wait_responses();
    end_test("refill then debug");

    // Both ways at every idx[1:0]
    for (int s = 0; s < 8; s++) begin
      idx_a = rand_idx();
      issue(1, s[2], {idx_a[11:2], s[1:0]});
    end
    wait_responses();
    end_test("fetch selection table");

    repeat (300) issue_random(1'b1);
    wait_responses();
    end_test("back to back mix");

    repeat (2000) begin
      issue_random(1'b0);
      if (rand_idx() < 12'd1024) issue(3, 1'b0, 12'd0);
    end
    wait_responses();
    end_test("long random run");

    $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+hw
hw/icache_access_pkg.sv
hw/icache_bank_pkg.sv
hw/icache_data_steer.sv
hw/icache_data_bank.sv
hw/icache_data_align.sv
hw/icache_data_array.sv
tb/icache_data_array_checker.sv
tb/icache_data_array_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module icache_data_array_tb -o sim_icache

# An assertion stop leaves no closing line, so the run status is checked from the log
./obj_dir/sim_icache > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
  exit 1
fi
grep -q "Verification passed" sim.log
